//--- hdl/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int NUM_WAYS    = 2;
    localparam int NUM_BANKS   = 4;                      // words per line
    localparam int INDEX_BITS  = 8;
    localparam int TAG_BITS    = 20;
    localparam int OFFSET_BITS = 4;                      // byte offset in a line
    localparam int WORD_BITS   = 32;
    localparam int LINE_BITS   = NUM_BANKS * WORD_BITS;

    typedef logic [INDEX_BITS-1:0]          index_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [OFFSET_BITS-1:0]         offset_t;
    typedef logic [$clog2(NUM_BANKS)-1:0]   bank_sel_t;  // offset[3:2] and the refill beat
    typedef logic [WORD_BITS-1:0]           word_t;
    typedef logic [WORD_BITS/8-1:0]         strb_t;
    typedef logic [LINE_BITS-1:0]           line_t;

    // one tag array entry with valid in bit 0
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // request as seen on the cpu side
    typedef struct packed {
        logic    op;       // 1 for store
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    // dirty victim going out on the write bus
    typedef struct packed {
        logic [31:0] addr;  // line aligned
        line_t       data;
    } line_wb_t;

    // per-bank sram command from the controller
    typedef struct packed {
        index_t addr;
        strb_t  wstrb;     // zero means read
        word_t  wdata;
    } bank_cmd_t;

endpackage

//--- hdl/cache_sram.sv
`timescale 1ns/1ps

module cache_sram #(
    parameter type entry_t    = logic [31:0],
    parameter int  DEPTH      = 256,
    parameter int  LANE_COUNT = 4
) (
    input  logic                  clk,
    input  dcache_pkg::index_t    addr,
    input  entry_t                wdata,
    input  logic [LANE_COUNT-1:0] we,
    output entry_t                rdata
);

    localparam int ENTRY_BITS = $bits(entry_t);
    localparam int LANE_BITS  = ENTRY_BITS / LANE_COUNT;

    logic [ENTRY_BITS-1:0] mem [DEPTH];
    logic [ENTRY_BITS-1:0] wbits;

    assign wbits = wdata;

    // output only refreshes on read cycles
    always_ff @(posedge clk) begin
        if (|we) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                if (we[l]) begin
                    mem[addr][l*LANE_BITS +: LANE_BITS] <= wbits[l*LANE_BITS +: LANE_BITS];
                end
            end
        end else begin
            rdata <= entry_t'(mem[addr]);
        end
    end

endmodule

//--- hdl/lfsr_way_pick.sv
`timescale 1ns/1ps

module lfsr_way_pick #(
    parameter logic [7:0] SEED = 8'h01
) (
    input  logic clk,
    input  logic reset,
    output logic random_way
);

    logic [7:0] lfsr;

    // galois form, feedback from bit 7 into taps 4..6
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[6],
                     lfsr[5] ^ lfsr[7],
                     lfsr[4] ^ lfsr[7],
                     lfsr[3] ^ lfsr[7],
                     lfsr[2:0],
                     lfsr[7]};
        end
    end

    assign random_way = lfsr[7];   // top bit picks the way

endmodule

//--- hdl/hit_select.sv
`timescale 1ns/1ps

module hit_select (
    input  dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] tagv,
    input  dcache_pkg::tag_t                             lookup_tag,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] lines,
    input  dcache_pkg::bank_sel_t                        word_sel,
    output logic [dcache_pkg::NUM_WAYS-1:0]              way_hit,
    output logic                                         hit,
    output dcache_pkg::word_t                            load_word
);

    import dcache_pkg::*;

    word_t [NUM_WAYS-1:0] way_word;

    // tag compare and word pick per way
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w]  = tagv[w].valid && (tagv[w].tag == lookup_tag);
            way_word[w] = lines[w][word_sel*WORD_BITS +: WORD_BITS];
        end
    end

    // at most one way hits, so an and-or mux is enough
    always_comb begin
        load_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            load_word = load_word | (way_word[w] & {WORD_BITS{way_hit[w]}});
        end
    end

    assign hit = |way_hit;

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                         clk,
    input  logic                                         reset,
    // cpu side
    input  logic                                         valid,
    input  dcache_pkg::cpu_req_t                         req,
    output logic                                         addr_ok,
    output logic                                         data_ok,
    output dcache_pkg::word_t                            rdata,
    // lookup results
    input  logic [dcache_pkg::NUM_WAYS-1:0]              way_hit,
    input  logic                                         hit,
    input  dcache_pkg::word_t                            load_word,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] lines,
    input  dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] tagv,
    input  logic                                         random_way,
    output dcache_pkg::tag_t                             lookup_tag,
    output dcache_pkg::bank_sel_t                        word_sel,
    // sram commands
    output dcache_pkg::bank_cmd_t
           [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_BANKS-1:0] bank_cmd,
    output dcache_pkg::index_t                           tagv_addr,
    output dcache_pkg::tagv_t                            tagv_wdata,
    output logic [dcache_pkg::NUM_WAYS-1:0]              tagv_we,
    // memory read bus
    output logic                                         rd_req,
    output logic [31:0]                                  rd_addr,
    input  logic                                         rd_rdy,
    input  logic                                         ret_valid,
    input  logic                                         ret_last,
    input  dcache_pkg::word_t                            ret_data,
    // memory write bus
    output logic                                         wr_req,
    output dcache_pkg::line_wb_t                         wr,
    input  logic                                         wr_rdy
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } state_t;

    state_t    state;
    cpu_req_t  req_buf;
    logic      victim_way;      // latched when leaving MISS
    bank_sel_t beat;            // refill word counter

    // hit-store write buffer
    logic      wb_full;
    logic      wb_way;
    index_t    wb_index;
    bank_sel_t wb_bank;
    strb_t     wb_wstrb;
    word_t     wb_wdata;

    logic [NUM_WAYS-1:0][(1 << INDEX_BITS)-1:0] dirty;

    bank_sel_t req_bank;
    bank_sel_t buf_bank;
    logic      idle_ok;
    logic      lookup_ok;
    logic      accept;
    logic      store_hit;
    logic      hit_way;
    logic      victim_pick;
    logic      refill_we;
    logic      refill_done;
    index_t    main_index;
    word_t     merged_word;
    word_t     refill_word;

    assign req_bank = req.offset[OFFSET_BITS-1:2];
    assign buf_bank = req_buf.offset[OFFSET_BITS-1:2];

    // bank conflicts with the write buffer and with a store still in lookup
    assign idle_ok   = !(wb_full && wb_bank == req_bank);
    assign lookup_ok = idle_ok && hit && !(req_buf.op && !req.op && buf_bank == req_bank);
    assign addr_ok   = (state == IDLE && idle_ok) || (state == LOOKUP && lookup_ok);
    assign accept    = valid && addr_ok;

    assign store_hit   = state == LOOKUP && hit && req_buf.op;
    assign refill_we   = state == REFILL && ret_valid;
    assign refill_done = refill_we && ret_last;

    assign lookup_tag = req_buf.tag;
    assign word_sel   = buf_bank;

    // stores answer in lookup even on a miss; loads on a miss wait for their beat
    assign data_ok = (state == LOOKUP && (hit || req_buf.op)) ||
                     (refill_we && !req_buf.op && beat == buf_bank);
    assign rdata   = (state == LOOKUP) ? load_word : ret_data;   // critical word forwarded

    always_comb begin
        hit_way = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = w[0];
            end
        end
    end

    // invalid way first, else random
    always_comb begin
        if (!tagv[0].valid) begin
            victim_pick = 1'b0;
        end else if (!tagv[1].valid) begin
            victim_pick = 1'b1;
        end else begin
            victim_pick = random_way;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            wr_req     <= 1'b0;
            victim_way <= 1'b0;
            beat       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (accept) begin
                        state <= LOOKUP;   // back to back hits
                    end else if (!hit) begin
                        state <= MISS;
                    end else begin
                        state <= IDLE;
                    end
                end
                MISS: begin
                    if (wr_rdy) begin
                        state      <= REPLACE;
                        victim_way <= victim_pick;
                        wr_req     <= tagv[victim_pick].valid && dirty[victim_pick][req_buf.index];
                    end
                end
                REPLACE: begin
                    wr_req <= 1'b0;        // single cycle pulse
                    if (rd_rdy) begin
                        state <= REFILL;
                        beat  <= '0;
                    end
                end
                REFILL: begin
                    if (ret_valid) begin
                        beat <= beat + 1'b1;
                        if (ret_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_full <= 1'b0;
        end else begin
            wb_full <= store_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wb_way   <= hit_way;
            wb_index <= req_buf.index;
            wb_bank  <= buf_bank;
            wb_wstrb <= req_buf.wstrb;
            wb_wdata <= req_buf.wdata;
        end
    end

    // refill sets dirty only for a store miss
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty <= '0;
        end else if (refill_done) begin
            dirty[victim_way][req_buf.index] <= req_buf.op;
        end else if (wb_full) begin
            dirty[wb_way][wb_index] <= 1'b1;
        end
    end

    // merge the buffered store into its refill word
    always_comb begin
        for (int i = 0; i < WORD_BITS / 8; i++) begin
            merged_word[i*8 +: 8] = req_buf.wstrb[i] ? req_buf.wdata[i*8 +: 8]
                                                     : ret_data[i*8 +: 8];
        end
    end

    assign refill_word = (req_buf.op && beat == buf_bank) ? merged_word : ret_data;
    assign main_index  = addr_ok ? req.index : req_buf.index;

    // write buffer owns its bank, the rest read or refill
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (wb_full && int'(wb_way) == w && int'(wb_bank) == b) begin
                    bank_cmd[w][b].addr  = wb_index;
                    bank_cmd[w][b].wstrb = wb_wstrb;
                    bank_cmd[w][b].wdata = wb_wdata;
                end else begin
                    bank_cmd[w][b].addr  = main_index;
                    bank_cmd[w][b].wstrb = (refill_we && int'(victim_way) == w &&
                                            int'(beat) == b) ? '1 : '0;
                    bank_cmd[w][b].wdata = refill_word;
                end
            end
        end
    end

    assign tagv_addr  = main_index;
    assign tagv_wdata = '{tag: req_buf.tag, valid: 1'b1};

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tagv_we[w] = refill_done && int'(victim_way) == w;   // tag lands with last beat
        end
    end

    assign rd_req  = state == REPLACE;
    assign rd_addr = {req_buf.tag, req_buf.index, {OFFSET_BITS{1'b0}}};

    assign wr.addr = {tagv[victim_way].tag, req_buf.index, {OFFSET_BITS{1'b0}}};
    assign wr.data = lines[victim_way];

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter logic [7:0] LFSR_SEED = 8'd1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  dcache_pkg::word_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::line_wb_t wr,
    input  logic                 wr_rdy
);

    import dcache_pkg::*;

    bank_cmd_t [NUM_WAYS-1:0][NUM_BANKS-1:0] bank_cmd;
    line_t     [NUM_WAYS-1:0]                lines;      // raw bank outputs per way
    tagv_t     [NUM_WAYS-1:0]                tagv;
    index_t                                  tagv_addr;
    tagv_t                                   tagv_wdata;
    logic      [NUM_WAYS-1:0]                tagv_we;
    logic      [NUM_WAYS-1:0]                way_hit;
    logic                                    hit;
    word_t                                   load_word;
    tag_t                                    lookup_tag;
    bank_sel_t                               word_sel;
    logic                                    random_way;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            cache_sram #(
                .entry_t    (word_t),
                .DEPTH      (1 << INDEX_BITS),
                .LANE_COUNT (WORD_BITS / 8)
            ) i_bank (
                .clk   (clk),
                .addr  (bank_cmd[w][b].addr),
                .wdata (bank_cmd[w][b].wdata),
                .we    (bank_cmd[w][b].wstrb),
                .rdata (lines[w][b*WORD_BITS +: WORD_BITS])
            );
        end

        cache_sram #(
            .entry_t    (tagv_t),
            .DEPTH      (1 << INDEX_BITS),
            .LANE_COUNT (1)
        ) i_tagv (
            .clk   (clk),
            .addr  (tagv_addr),
            .wdata (tagv_wdata),
            .we    (tagv_we[w]),
            .rdata (tagv[w])
        );
    end

    hit_select i_hit_select (
        .tagv       (tagv),
        .lookup_tag (lookup_tag),
        .lines      (lines),
        .word_sel   (word_sel),
        .way_hit    (way_hit),
        .hit        (hit),
        .load_word  (load_word)
    );

    dcache_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .req        (req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .way_hit    (way_hit),
        .hit        (hit),
        .load_word  (load_word),
        .lines      (lines),
        .tagv       (tagv),
        .random_way (random_way),
        .lookup_tag (lookup_tag),
        .word_sel   (word_sel),
        .bank_cmd   (bank_cmd),
        .tagv_addr  (tagv_addr),
        .tagv_wdata (tagv_wdata),
        .tagv_we    (tagv_we),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr         (wr),
        .wr_rdy     (wr_rdy)
    );

    lfsr_way_pick #(
        .SEED (LFSR_SEED)
    ) i_lfsr (
        .clk        (clk),
        .reset      (reset),
        .random_way (random_way)
    );

endmodule

//--- testbench/dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties (
    input logic        clk,
    input logic        reset,
    input logic        valid,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        rd_req,
    input logic [31:0] rd_addr,
    input logic        rd_rdy,
    input logic        wr_req
);

    logic [3:0]  outstanding;   // accepted requests still waiting for data_ok
    int unsigned failures = 0;  // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(valid && addr_ok) - 4'(data_ok);
        end
    end

    wr_pulse: assert property (@(posedge clk) disable iff (reset) wr_req |=> !wr_req)
        else begin
            failures++;
            $error("wr_req high in two consecutive cycles");
        end

    rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            failures++;
            $error("rd_req or rd_addr changed before rd_rdy");
        end

    answer_owed: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> outstanding != 0)
        else begin
            failures++;
            $error("data_ok without an outstanding request");
        end

    quiet_after_reset: assert property (@(posedge clk) reset |=> !rd_req && !wr_req)
        else begin
            failures++;
            $error("memory bus request right after reset");
        end

endmodule

bind dcache_top dcache_properties i_props (.*);

//--- testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int NUM_OPS      = 400;
    localparam int DIRECTED_OPS = 40;
    localparam int SEED         = 99;
    localparam int CLK_PERIOD   = 20;
    localparam int TAG_POOL     = 3;
    localparam int OP_CYCLES    = 80;     // generous bound for one miss with writeback

    typedef struct packed {
        logic        is_store;
        logic        check_timing;   // must hit with data_ok one cycle after acceptance
        logic [31:0] addr;
        word_t       expected;
        logic [31:0] accept_cycle;
    } pending_t;

    logic        clk;
    logic        reset;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    line_wb_t    wr;
    logic        wr_rdy;

    pending_t    pending_q [$];
    logic [7:0]  ref_mem [int unsigned];     // byte-addressed cpu view
    word_t       back_mem [int unsigned];    // memory behind the cache
    bit          dirty_lines [int unsigned]; // lines stored to since last writeback
    logic [31:0] last_accepted;              // newest accepted request
    int unsigned errors;
    int unsigned checks;
    int unsigned cycle;

    tag_t tag_pool [TAG_POOL] = '{20'h01a2b, 20'h3c4d5, 20'h7e6f7};

    dcache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic word_t pattern(logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t backing_word(logic [31:0] a);
        return back_mem.exists(a) ? back_mem[a] : pattern(a);
    endfunction

    function automatic word_t model_word(logic [31:0] a);
        word_t w;
        word_t init;
        init = pattern(a);
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = ref_mem.exists(a + 32'(i)) ? ref_mem[a + 32'(i)] : init[i*8 +: 8];
        end
        return w;
    endfunction

    function automatic line_t model_line(logic [31:0] base);
        line_t l;
        for (int b = 0; b < NUM_BANKS; b++) begin
            l[b*WORD_BITS +: WORD_BITS] = model_word(base + 32'(4 * b));
        end
        return l;
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_line(input string name, input line_wb_t expected,
                                input line_wb_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // present one request and return once it is taken at the coming edge
    task automatic issue(input logic is_store, input logic [31:0] addr, input strb_t wstrb,
                         input word_t wdata, input logic check_timing);
        pending_t p;
        @(negedge clk);
        valid      = 1'b1;
        req.op     = is_store;
        req.tag    = addr[31:12];
        req.index  = addr[11:4];
        req.offset = addr[3:0];
        req.wstrb  = is_store ? wstrb : '0;
        req.wdata  = wdata;
        #(CLK_PERIOD / 4);
        while (!addr_ok) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        p.is_store     = is_store;
        p.check_timing = check_timing;
        p.addr         = addr;
        p.expected     = is_store ? '0 : model_word(addr);
        p.accept_cycle = cycle;
        last_accepted  = addr;
        if (is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    ref_mem[addr + 32'(i)] = wdata[i*8 +: 8];
                end
            end
            dirty_lines[{addr[31:4], 4'h0}] = 1'b1;
        end
        pending_q.push_back(p);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            valid = 1'b0;
        end
    endtask

    // sample cpu answers and writebacks mid low phase
    initial begin
        pending_t p;
        line_wb_t exp_wb;
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            if (reset === 1'b0) begin
                if (data_ok) begin
                    if (pending_q.size() == 0) begin
                        errors++;
                        $display("data_ok seen with no request outstanding at cycle %0d", cycle);
                    end else begin
                        p = pending_q.pop_front();
                        if (!p.is_store) begin
                            compare_word($sformatf("load %h", p.addr), p.expected, rdata);
                        end
                        if (p.check_timing && cycle != p.accept_cycle + 1) begin
                            errors++;
                            $display("repeated load at %h answered %0d cycles after acceptance",
                                     p.addr, cycle - p.accept_cycle);
                        end
                    end
                end
                if (wr_req) begin
                    if (!dirty_lines.exists(wr.addr)) begin
                        errors++;
                        $display("writeback of line %h that was never stored to", wr.addr);
                    end
                    // victim lies in the set of the request that missed
                    exp_wb.addr = {wr.addr[31:12], last_accepted[11:4], 4'h0};
                    exp_wb.data = model_line(exp_wb.addr);
                    compare_line($sformatf("writeback %h", wr.addr), exp_wb, wr);
                    dirty_lines.delete(wr.addr);
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        back_mem[wr.addr + 32'(4 * b)] = wr.data[b*WORD_BITS +: WORD_BITS];
                    end
                end
            end
        end
    end

    // memory read side with random accept delay and beat gaps
    initial begin
        logic [31:0] line_addr;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            if (rd_req === 1'b1) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                line_addr = rd_addr;
                rd_rdy    = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int b = 0; b < NUM_BANKS; b++) begin
                    repeat ($urandom_range(0, 2)) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (b == NUM_BANKS - 1);
                    ret_data  = backing_word(line_addr + 32'(4 * b));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    initial begin
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            wr_rdy = ($urandom_range(0, 3) != 0);   // busy one time in four
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_OPS + DIRECTED_OPS) * OP_CYCLES);
        $display("timeout: run did not finish in %0d cycles", cycle);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] a;
        void'($urandom(SEED));
        reset         = 1'b1;
        valid         = 1'b0;
        req           = '0;
        rd_rdy        = 1'b0;
        ret_valid     = 1'b0;
        ret_last      = 1'b0;
        ret_data      = '0;
        wr_rdy        = 1'b1;
        last_accepted = '0;
        errors        = 0;
        checks        = 0;
        cycle         = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        issue(1'b0, 32'h0004_0128, '0, '0, 1'b0);             // cold load
        idle(3);
        issue(1'b1, 32'h0004_0124, 4'b0101, 32'hdead_beef, 1'b0);
        issue(1'b0, 32'h0004_0124, '0, '0, 1'b0);             // same bank right behind
        idle(3);
        issue(1'b1, 32'h0008_0334, 4'b1100, 32'h1357_9bdf, 1'b0);   // store miss
        issue(1'b0, 32'h0008_0334, '0, '0, 1'b0);
        idle(3);
        // three tags on one set
        for (int t = 0; t < TAG_POOL; t++) begin
            issue(1'b1, {tag_pool[t], 8'h55, 4'h4}, 4'b1111, $urandom, 1'b0);
        end
        for (int t = 0; t < TAG_POOL; t++) begin
            issue(1'b0, {tag_pool[t], 8'h55, 4'h4}, '0, '0, 1'b0);
        end
        idle(3);
        issue(1'b0, 32'h000c_0a08, '0, '0, 1'b0);
        issue(1'b0, 32'h000c_0a08, '0, '0, 1'b1);             // must hit
        idle(3);

        for (int n = 0; n < NUM_OPS; n++) begin
            a = {tag_pool[$urandom_range(0, TAG_POOL - 1)],
                 8'h20 + 8'($urandom_range(0, 3)),
                 2'($urandom_range(0, 3)), 2'b00};
            issue(1'($urandom_range(0, 1)), a, 4'($urandom_range(1, 15)), $urandom, 1'b0);
            if ($urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, 3));
            end
        end
        idle(1);
        while (pending_q.size() != 0) @(negedge clk);
        #(CLK_PERIOD / 4);
        while (addr_ok !== 1'b1) begin   // a last store miss may still refill
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_props.failures);
        if (errors == 0 && i_dut.i_props.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/dcache_pkg.sv
hdl/cache_sram.sv
hdl/lfsr_way_pick.sv
hdl/hit_select.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= dcache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
